/* vlog.f */
hdl/ls_isa_pkg.sv
hdl/lsu_cfg_pkg.sv
hdl/load_store_queue.sv
hdl/scratch_mem_unit.sv
hdl/bus_master_unit.sv
hdl/load_store_unit.sv
dv/lsu_tb.sv

/* run.sh */
#!/bin/sh
# Build the load/store unit testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module lsu_tb -f vlog.f -o lsu_sim
./obj_dir/lsu_sim

/* dv/lsu_testdata.txt */
# op fn3 rs1 offset rs2 expected exc  (hex fields, offset is a 12-bit immediate)
# expected is the load result, or the faulting address when exc is 1
# Scratch stores
S 2 00000100 000 a1b2c3d4 00000000 0
S 2 00000100 004 80ff7f01 00000000 0
S 2 00000200 ffc 12345678 00000000 0
S 0 00000108 000 000000aa 00000000 0
S 0 00000108 001 000000bb 00000000 0
S 0 00000108 002 000000cc 00000000 0
S 0 00000108 003 000000dd 00000000 0
S 1 0000010c 000 00001234 00000000 0
S 1 0000010c 002 0000fedc 00000000 0
# Scratch word loads
L 2 00000100 000 00000000 a1b2c3d4 0
L 2 00000108 000 00000000 ddccbbaa 0
L 2 00000110 ffc 00000000 fedc1234 0
L 2 00000200 ffc 00000000 12345678 0
# Byte and half loads
L 0 00000104 000 00000000 00000001 0
L 0 00000105 000 00000000 0000007f 0
L 0 00000104 002 00000000 ffffffff 0
L 0 00000104 003 00000000 ffffff80 0
L 4 00000104 002 00000000 000000ff 0
L 4 00000104 003 00000000 00000080 0
L 1 00000104 000 00000000 00007f01 0
L 1 00000104 002 00000000 ffff80ff 0
L 5 00000104 002 00000000 000080ff 0
L 5 00000108 002 00000000 0000ddcc 0
L 0 00000108 001 00000000 ffffffbb 0
# Misaligned accesses
L 1 00000104 001 00000000 00000105 1
L 2 00000104 002 00000000 00000106 1
S 2 00000100 003 deadbeef 00000103 1
S 1 00000101 000 0000beef 00000101 1
L 2 00000104 000 00000000 80ff7f01 0
# Bus region
S 2 80000000 000 cafef00d 00000000 0
S 0 80000000 001 00000055 00000000 0
S 1 80000000 002 00001234 00000000 0
L 2 80000000 000 00000000 1234550d 0
L 0 80000001 000 00000000 00000055 0
L 5 80000000 002 00000000 00001234 0
L 2 80000040 000 00000000 10ef4ac3 0
L 1 80000044 ffe 00000000 000010ef 0
# Interleaved scratch and bus
L 2 00000100 000 00000000 a1b2c3d4 0
L 2 80000000 000 00000000 1234550d 0
L 0 00000104 002 00000000 ffffffff 0
L 4 80000040 003 00000000 00000010 0
S 2 80000020 000 11223344 00000000 0
L 2 000001fc 000 00000000 12345678 0
L 2 80000020 000 00000000 11223344 0
L 0 80000044 000 00000000 ffffffc3 0
L 2 00000108 000 00000000 ddccbbaa 0

/* dv/lsu_tb.sv */
`timescale 1ns/1ps

module lsu_tb;

    localparam string DATA_FILE = "dv/lsu_testdata.txt";
    localparam int CYCLES_PER_OP = 200;

    typedef struct packed {
        ls_isa_pkg::ls_request_t req;
        ls_isa_pkg::word_t       expected;
        logic                    exc;
        logic                    group_start;
    } test_op_t;

    typedef struct packed {
        ls_isa_pkg::id_t   id;
        ls_isa_pkg::word_t result;
        logic              timed;
        logic [31:0]       due;
    } wb_expect_t;

    logic clk = 1'b0;
    logic rst;
    logic issue_valid = 1'b0;
    ls_isa_pkg::ls_request_t issue_req = '0;
    logic issue_credit;
    ls_isa_pkg::exception_packet_t exception;
    logic wb_valid;
    lsu_cfg_pkg::wb_packet_t wb;
    logic bus_req_valid;
    ls_isa_pkg::word_t bus_addr;
    logic bus_we;
    lsu_cfg_pkg::byte_en_t bus_be;
    ls_isa_pkg::word_t bus_wdata;
    logic bus_ack = 1'b0;
    ls_isa_pkg::word_t bus_rdata = '0;
    logic idle;

    test_op_t ops[$];
    test_op_t cur_op = '0;
    wb_expect_t wb_q[$];
    int next_op = 0;
    int credits = 0;
    int cycle = 0;
    logic loaded = 1'b0;

    ls_isa_pkg::word_t bus_mem [256];
    ls_isa_pkg::word_t lfsr = 32'h32bc_2e9b;
    logic bus_busy = 1'b0;
    logic [1:0] bus_wait = '0;

    load_store_unit DUT (.*);

    always #50 clk = ~clk;

    //////////////////////////////////////////////////
    // Helpers
    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_value(string name, ls_isa_pkg::word_t actual,
                               ls_isa_pkg::word_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED at %0t ns: %s is %h, expected %h",
                                $time, name, actual, expected));
        end
    endtask

    function automatic ls_isa_pkg::word_t lfsr_next(ls_isa_pkg::word_t state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    // A comment line in the data file opens a new group of operations
    task automatic load_ops();
        int fd;
        string line;
        logic [7:0] op_ch;
        logic [2:0] fn3_v;
        ls_isa_pkg::word_t rs1_v;
        logic [11:0] off_v;
        ls_isa_pkg::word_t rs2_v;
        ls_isa_pkg::word_t exp_v;
        logic exc_v;
        logic new_group;
        test_op_t op;
        new_group = 1'b1;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            abort_run({"Could not open the data file ", DATA_FILE});
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 0 && line[0] == "#") begin
                new_group = 1'b1;
            end else if ($sscanf(line, "%s %h %h %h %h %h %h", op_ch, fn3_v, rs1_v, off_v,
                                 rs2_v, exp_v, exc_v) == 7) begin
                if (op_ch != "L" && op_ch != "S") begin
                    abort_run({"Unknown operation in data line: ", line});
                end
                op.req.rs1 = rs1_v;
                op.req.offset = off_v;
                op.req.rs2 = rs2_v;
                op.req.fn3 = ls_isa_pkg::fn3_t'(fn3_v);
                op.req.load = (op_ch == "L");
                op.req.store = (op_ch == "S");
                op.req.id = ls_isa_pkg::id_t'(ops.size());
                op.expected = exp_v;
                op.exc = exc_v;
                op.group_start = new_group;
                new_group = 1'b0;
                ops.push_back(op);
            end
        end
        $fclose(fd);
        if (ops.size() == 0) begin
            abort_run("The data file holds no operations");
        end
    endtask

    //////////////////////////////////////////////////
    // Issuer with credit counter
    always @(posedge clk) begin
        logic drained;
        if (rst) begin
            credits = lsu_cfg_pkg::LSQ_DEPTH;
            issue_valid <= 1'b0;
        end else begin
            if (issue_credit) begin
                credits = credits + 1;
            end
            // Group starts wait for an empty unit
            drained = ~issue_valid & idle & (credits == lsu_cfg_pkg::LSQ_DEPTH);
            if (next_op < ops.size() && credits > 0
                && (!ops[next_op].group_start || drained)) begin
                issue_valid <= 1'b1;
                issue_req <= ops[next_op].req;
                cur_op <= ops[next_op];
                credits = credits - 1;
                next_op = next_op + 1;
            end else begin
                issue_valid <= 1'b0;
            end
            if (credits < 0 || credits > lsu_cfg_pkg::LSQ_DEPTH) begin
                abort_run($sformatf("Issue credit counter left its range, now %0d", credits));
            end
        end
    end

    //////////////////////////////////////////////////
    // Bus memory model acknowledging after 1 to 4 cycles
    always @(posedge clk) begin
        if (rst) begin
            bus_ack <= 1'b0;
            bus_busy = 1'b0;
            for (int i = 0; i < 256; i++) begin
                bus_mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3};
            end
        end else if (bus_ack) begin
            bus_ack <= 1'b0;
        end else if (bus_req_valid) begin
            if (!bus_busy) begin
                bus_busy = 1'b1;
                lfsr = lfsr_next(lfsr);
                bus_wait[0] = lfsr[0];
                lfsr = lfsr_next(lfsr);
                bus_wait[1] = lfsr[0];
            end
            if (bus_wait == 2'd0) begin
                bus_busy = 1'b0;
                bus_ack <= 1'b1;
                if (bus_we) begin
                    for (int i = 0; i < 4; i++) begin
                        if (bus_be[i]) begin
                            bus_mem[bus_addr[9:2]][i*8 +: 8] = bus_wdata[i*8 +: 8];
                        end
                    end
                end
                bus_rdata <= bus_mem[bus_addr[9:2]];
            end else begin
                bus_wait = bus_wait - 2'd1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Exception and writeback monitor
    always @(posedge clk) begin
        wb_expect_t exp_wb;
        ls_isa_pkg::word_t eff;
        if (rst) begin
            cycle = 0;
        end else begin
            cycle = cycle + 1;
            check_value("exception.valid", 32'(exception.valid), 32'(issue_valid & cur_op.exc));
            if (issue_valid && cur_op.exc) begin
                check_value("exception.code", 32'(exception.code),
                            cur_op.req.store ? 32'd6 : 32'd4);
                check_value("exception.tval", exception.tval, cur_op.expected);
                check_value("exception.id", 32'(exception.id), 32'(cur_op.req.id));
            end
            if (issue_valid && !cur_op.exc && cur_op.req.load) begin
                eff = cur_op.req.rs1 + {{20{cur_op.req.offset[11]}}, cur_op.req.offset};
                exp_wb.id = cur_op.req.id;
                exp_wb.result = cur_op.expected;
                // Scratch load into an idle unit has fixed latency
                exp_wb.timed = idle & ~eff[31];
                exp_wb.due = 32'(cycle + 2);
                wb_q.push_back(exp_wb);
            end
            if (wb_valid) begin
                if (wb_q.size() == 0) begin
                    abort_run("A writeback arrived while no load was outstanding");
                end
                exp_wb = wb_q.pop_front();
                check_value("wb.id", 32'(wb.id), 32'(exp_wb.id));
                check_value("wb.result", wb.result, exp_wb.result);
                if (exp_wb.timed) begin
                    check_value("writeback cycle", 32'(cycle), exp_wb.due);
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Watchdog
    initial begin
        wait (loaded);
        repeat (10 + CYCLES_PER_OP * ops.size()) @(posedge clk);
        abort_run($sformatf("Timeout after %0d cycles with %0d of %0d operations issued",
                            10 + CYCLES_PER_OP * ops.size(), next_op, ops.size()));
    end

    // Main sequence
    initial begin
        rst = 1'b1;
        load_ops();
        loaded = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("issue_credit", 32'(issue_credit), 32'd0);
        check_value("wb_valid", 32'(wb_valid), 32'd0);
        check_value("bus_req_valid", 32'(bus_req_valid), 32'd0);
        check_value("idle", 32'(idle), 32'd1);

        while (next_op < ops.size()) begin
            @(negedge clk);
        end
        while (issue_valid || credits != lsu_cfg_pkg::LSQ_DEPTH || wb_q.size() != 0) begin
            @(negedge clk);
        end
        // Room for a trailing bus store and any stray writeback
        repeat (5) @(negedge clk);
        check_value("idle", 32'(idle), 32'd1);
        $display("Testbench passed");
        $finish;
    end

endmodule

/* hdl/load_store_unit.sv */
`timescale 1ns/1ps

module load_store_unit (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          issue_valid,
    input  ls_isa_pkg::ls_request_t       issue_req,
    output logic                          issue_credit,
    output ls_isa_pkg::exception_packet_t exception,
    output logic                          wb_valid,
    output lsu_cfg_pkg::wb_packet_t       wb,
    output logic                          bus_req_valid,
    output ls_isa_pkg::word_t             bus_addr,
    output logic                          bus_we,
    output lsu_cfg_pkg::byte_en_t         bus_be,
    output ls_isa_pkg::word_t             bus_wdata,
    input  logic                          bus_ack,
    input  ls_isa_pkg::word_t             bus_rdata,
    output logic                          idle
);

    ls_isa_pkg::word_t eff_addr;
    ls_isa_pkg::word_t store_data;
    lsu_cfg_pkg::byte_en_t be;
    logic misaligned;
    lsu_cfg_pkg::lsq_entry_t enq_entry;
    logic enq;
    lsu_cfg_pkg::lsq_entry_t head;
    logic head_valid;
    logic lsq_empty;
    logic lsq_credit;
    logic deq;
    logic reject_credit;
    logic credit_pending;

    lsu_cfg_pkg::unit_sel_t cur_unit;
    lsu_cfg_pkg::unit_sel_t last_unit;
    logic unit_switch_stall;
    logic [lsu_cfg_pkg::NUM_UNITS-1:0] unit_ready;
    logic [lsu_cfg_pkg::NUM_UNITS-1:0] unit_data_valid;
    ls_isa_pkg::word_t unit_data [lsu_cfg_pkg::NUM_UNITS];

    lsu_cfg_pkg::load_attr_t attr_mem [lsu_cfg_pkg::ATTR_DEPTH];
    lsu_cfg_pkg::load_attr_t attr_head;
    lsu_cfg_pkg::attr_ptr_t attr_wr_ptr;
    lsu_cfg_pkg::attr_ptr_t attr_rd_ptr;
    lsu_cfg_pkg::attr_count_t attr_count;
    logic attr_empty;
    logic attr_full;
    logic attr_push;
    logic load_complete;
    ls_isa_pkg::word_t shifted_data;

    //////////////////////////////////////////////////
    // Address generation and alignment check
    assign eff_addr = issue_req.rs1 + {{20{issue_req.offset[11]}}, issue_req.offset};

    always_comb begin
        case (issue_req.fn3)
            ls_isa_pkg::FN3_H, ls_isa_pkg::FN3_HU: misaligned = eff_addr[0];
            ls_isa_pkg::FN3_W:                      misaligned = |eff_addr[1:0];
            default:                                misaligned = 1'b0;
        endcase
    end

    assign exception.valid = issue_valid & misaligned;
    assign exception.code = issue_req.store ? ls_isa_pkg::EXC_STORE_MISALIGNED
                                            : ls_isa_pkg::EXC_LOAD_MISALIGNED;
    assign exception.tval = eff_addr;
    assign exception.id = issue_req.id;

    // Byte lanes with the store data replicated across them
    always_comb begin
        case (issue_req.fn3)
            ls_isa_pkg::FN3_B, ls_isa_pkg::FN3_BU: begin
                be = 4'b0001 << eff_addr[1:0];
                store_data = {4{issue_req.rs2[7:0]}};
            end
            ls_isa_pkg::FN3_H, ls_isa_pkg::FN3_HU: begin
                be = eff_addr[1] ? 4'b1100 : 4'b0011;
                store_data = {2{issue_req.rs2[15:0]}};
            end
            default: begin
                be = 4'b1111;
                store_data = issue_req.rs2;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Queue
    assign enq_entry.addr = eff_addr;
    assign enq_entry.be = be;
    assign enq_entry.data = store_data;
    assign enq_entry.fn3 = issue_req.fn3;
    assign enq_entry.load = issue_req.load;
    assign enq_entry.store = issue_req.store;
    assign enq_entry.id = issue_req.id;
    assign enq = issue_valid & ~misaligned & (issue_req.load | issue_req.store);

    load_store_queue lsq (
        .clk        (clk),
        .rst        (rst),
        .enq        (enq),
        .enq_entry  (enq_entry),
        .deq        (deq),
        .head_valid (head_valid),
        .head       (head),
        .empty      (lsq_empty),
        .credit     (lsq_credit)
    );

    // Rejected requests return their credit a cycle later
    // A collision with a queue credit pushes one out by a cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            reject_credit <= 1'b0;
            credit_pending <= 1'b0;
        end else begin
            reject_credit <= exception.valid;
            credit_pending <= (lsq_credit & reject_credit) | (lsq_credit & credit_pending)
                            | (reject_credit & credit_pending);
        end
    end

    assign issue_credit = lsq_credit | reject_credit | credit_pending;

    //////////////////////////////////////////////////
    // Sub-unit selection
    assign cur_unit = head.addr[lsu_cfg_pkg::BUS_SELECT_BIT];

    // Results from two units could otherwise land in the same cycle
    assign unit_switch_stall = (cur_unit != last_unit) & ~attr_empty;
    assign deq = head_valid & unit_ready[cur_unit] & ~unit_switch_stall
               & ~(head.load & attr_full);
    assign attr_push = deq & head.load;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_unit <= lsu_cfg_pkg::SCRATCH_ID;
        end else if (attr_push) begin
            last_unit <= cur_unit;
        end
    end

    scratch_mem_unit scratch (
        .clk         (clk),
        .rst         (rst),
        .new_request (deq && cur_unit == lsu_cfg_pkg::SCRATCH_ID),
        .entry       (head),
        .ready       (unit_ready[lsu_cfg_pkg::SCRATCH_ID]),
        .data_valid  (unit_data_valid[lsu_cfg_pkg::SCRATCH_ID]),
        .data_out    (unit_data[lsu_cfg_pkg::SCRATCH_ID])
    );

    bus_master_unit bus (
        .clk           (clk),
        .rst           (rst),
        .new_request   (deq && cur_unit == lsu_cfg_pkg::BUS_ID),
        .entry         (head),
        .bus_ack       (bus_ack),
        .bus_rdata     (bus_rdata),
        .ready         (unit_ready[lsu_cfg_pkg::BUS_ID]),
        .data_valid    (unit_data_valid[lsu_cfg_pkg::BUS_ID]),
        .data_out      (unit_data[lsu_cfg_pkg::BUS_ID]),
        .bus_req_valid (bus_req_valid),
        .bus_addr      (bus_addr),
        .bus_we        (bus_we),
        .bus_be        (bus_be),
        .bus_wdata     (bus_wdata)
    );

    //////////////////////////////////////////////////
    // Load attribute FIFO
    assign load_complete = |unit_data_valid;
    assign attr_empty = (attr_count == '0);
    assign attr_full = (attr_count == lsu_cfg_pkg::attr_count_t'(lsu_cfg_pkg::ATTR_DEPTH));
    assign attr_head = attr_mem[attr_rd_ptr];

    always_ff @(posedge clk) begin
        if (attr_push) begin
            attr_mem[attr_wr_ptr] <= '{fn3: head.fn3, byte_addr: head.addr[1:0],
                                       id: head.id, unit: cur_unit};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            attr_wr_ptr <= '0;
            attr_rd_ptr <= '0;
            attr_count <= '0;
        end else begin
            if (attr_push) begin
                attr_wr_ptr <= attr_wr_ptr + 1'b1;
            end
            if (load_complete) begin
                attr_rd_ptr <= attr_rd_ptr + 1'b1;
            end
            case ({attr_push, load_complete})
                2'b10:   attr_count <= attr_count + 1'b1;
                2'b01:   attr_count <= attr_count - 1'b1;
                default: attr_count <= attr_count;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Load alignment and extension
    assign shifted_data = unit_data[attr_head.unit] >> {attr_head.byte_addr, 3'b000};

    always_comb begin
        case (attr_head.fn3)
            ls_isa_pkg::FN3_B:  wb.result = {{24{shifted_data[7]}}, shifted_data[7:0]};
            ls_isa_pkg::FN3_BU: wb.result = {24'b0, shifted_data[7:0]};
            ls_isa_pkg::FN3_H:  wb.result = {{16{shifted_data[15]}}, shifted_data[15:0]};
            ls_isa_pkg::FN3_HU: wb.result = {16'b0, shifted_data[15:0]};
            default:            wb.result = shifted_data;
        endcase
    end

    assign wb.id = attr_head.id;
    assign wb_valid = load_complete;

    assign idle = lsq_empty & attr_empty & unit_ready[lsu_cfg_pkg::BUS_ID];

endmodule

/* hdl/bus_master_unit.sv */
`timescale 1ns/1ps

module bus_master_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    new_request,
    input  lsu_cfg_pkg::lsq_entry_t entry,
    input  logic                    bus_ack,
    input  ls_isa_pkg::word_t       bus_rdata,
    output logic                    ready,
    output logic                    data_valid,
    output ls_isa_pkg::word_t       data_out,
    output logic                    bus_req_valid,
    output ls_isa_pkg::word_t       bus_addr,
    output logic                    bus_we,
    output lsu_cfg_pkg::byte_en_t   bus_be,
    output ls_isa_pkg::word_t       bus_wdata
);

    typedef enum logic {
        IDLE,
        WAIT_ACK
    } state_t;

    state_t state;

    assign ready = (state == IDLE);
    assign bus_req_valid = (state == WAIT_ACK);

    //////////////////////////////////////////////////
    // Control
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            data_valid <= 1'b0;
        end else begin
            data_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (new_request) begin
                        state <= WAIT_ACK;
                    end
                end
                WAIT_ACK: begin
                    if (bus_ack) begin
                        state <= IDLE;
                        data_valid <= ~bus_we;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Request and response holding registers
    always_ff @(posedge clk) begin
        if (new_request && state == IDLE) begin
            bus_addr <= entry.addr;
            bus_we <= entry.store;
            bus_be <= entry.be;
            bus_wdata <= entry.data;
        end
        if (state == WAIT_ACK && bus_ack) begin
            data_out <= bus_rdata;
        end
    end

endmodule

/* hdl/scratch_mem_unit.sv */
`timescale 1ns/1ps

module scratch_mem_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    new_request,
    input  lsu_cfg_pkg::lsq_entry_t entry,
    output logic                    ready,
    output logic                    data_valid,
    output ls_isa_pkg::word_t       data_out
);

    ls_isa_pkg::word_t mem [lsu_cfg_pkg::SCRATCH_WORDS];
    lsu_cfg_pkg::scratch_addr_t index;

    // Word index with the byte offset bits dropped
    assign index = entry.addr[lsu_cfg_pkg::SCRATCH_ADDR_W+1:2];

    // Single cycle access so never busy
    assign ready = 1'b1;

    //////////////////////////////////////////////////
    // Memory array
    always_ff @(posedge clk) begin
        if (new_request && entry.store) begin
            for (int i = 0; i < 4; i++) begin
                if (entry.be[i]) begin
                    mem[index][i*8 +: 8] <= entry.data[i*8 +: 8];
                end
            end
        end
        if (new_request && entry.load) begin
            data_out <= mem[index];
        end
    end

    // Read strobe lines up with registered data
    always_ff @(posedge clk) begin
        if (rst) begin
            data_valid <= 1'b0;
        end else begin
            data_valid <= new_request & entry.load;
        end
    end

endmodule

/* hdl/load_store_queue.sv */
`timescale 1ns/1ps

module load_store_queue (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    enq,
    input  lsu_cfg_pkg::lsq_entry_t enq_entry,
    input  logic                    deq,
    output logic                    head_valid,
    output lsu_cfg_pkg::lsq_entry_t head,
    output logic                    empty,
    output logic                    credit
);

    lsu_cfg_pkg::lsq_entry_t entries [lsu_cfg_pkg::LSQ_DEPTH];
    lsu_cfg_pkg::lsq_ptr_t wr_ptr;
    lsu_cfg_pkg::lsq_ptr_t rd_ptr;
    lsu_cfg_pkg::lsq_count_t count;
    logic do_deq;

    assign empty = (count == '0);
    assign head_valid = ~empty;
    assign head = entries[rd_ptr];
    assign do_deq = deq & head_valid;

    // Entry storage
    always_ff @(posedge clk) begin
        if (enq) begin
            entries[wr_ptr] <= enq_entry;
        end
    end

    //////////////////////////////////////////////////
    // Pointers and occupancy
    // Depth is a power of two so the pointers wrap on their own
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (enq) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_deq) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({enq, do_deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // One issue credit per freed slot
    always_ff @(posedge clk) begin
        if (rst) begin
            credit <= 1'b0;
        end else begin
            credit <= do_deq;
        end
    end

endmodule

/* hdl/lsu_cfg_pkg.sv */
package lsu_cfg_pkg;

    //////////////////////////////////////////////////
    // Sizes
    localparam int LSQ_DEPTH = 4;
    localparam int ATTR_DEPTH = 2;
    localparam int SCRATCH_WORDS = 256;
    localparam int NUM_UNITS = 2;

    localparam int LSQ_PTR_W = $clog2(LSQ_DEPTH);
    localparam int LSQ_CNT_W = $clog2(LSQ_DEPTH + 1);
    localparam int ATTR_PTR_W = $clog2(ATTR_DEPTH);
    localparam int ATTR_CNT_W = $clog2(ATTR_DEPTH + 1);
    localparam int SCRATCH_ADDR_W = $clog2(SCRATCH_WORDS);

    // Upper half of the address space is the external bus
    localparam int BUS_SELECT_BIT = 31;

    typedef logic [$clog2(NUM_UNITS)-1:0] unit_sel_t;
    typedef logic [3:0] byte_en_t;
    typedef logic [LSQ_PTR_W-1:0] lsq_ptr_t;
    typedef logic [LSQ_CNT_W-1:0] lsq_count_t;
    typedef logic [ATTR_PTR_W-1:0] attr_ptr_t;
    typedef logic [ATTR_CNT_W-1:0] attr_count_t;
    typedef logic [SCRATCH_ADDR_W-1:0] scratch_addr_t;

    localparam unit_sel_t SCRATCH_ID = 1'b0;
    localparam unit_sel_t BUS_ID = 1'b1;

    //////////////////////////////////////////////////
    // Internal packets
    typedef struct packed {
        ls_isa_pkg::word_t addr;
        byte_en_t          be;
        ls_isa_pkg::word_t data;
        ls_isa_pkg::fn3_t  fn3;
        logic              load;
        logic              store;
        ls_isa_pkg::id_t   id;
    } lsq_entry_t;

    typedef struct packed {
        ls_isa_pkg::fn3_t fn3;
        logic [1:0]       byte_addr;
        ls_isa_pkg::id_t  id;
        unit_sel_t        unit;
    } load_attr_t;

    typedef struct packed {
        ls_isa_pkg::id_t   id;
        ls_isa_pkg::word_t result;
    } wb_packet_t;

endpackage

/* hdl/ls_isa_pkg.sv */
package ls_isa_pkg;

    //////////////////////////////////////////////////
    // Data and tag types
    typedef logic [31:0] word_t;
    typedef logic signed [11:0] offset_t;
    typedef logic [2:0] id_t;

    // RISC-V load/store width field
    typedef enum logic [2:0] {
        FN3_B  = 3'b000,
        FN3_H  = 3'b001,
        FN3_W  = 3'b010,
        FN3_BU = 3'b100,
        FN3_HU = 3'b101
    } fn3_t;

    // mcause values for misaligned accesses
    typedef enum logic [4:0] {
        EXC_LOAD_MISALIGNED  = 5'd4,
        EXC_STORE_MISALIGNED = 5'd6
    } exc_code_t;

    //////////////////////////////////////////////////
    // Packets
    typedef struct packed {
        logic      valid;
        exc_code_t code;
        word_t     tval;
        id_t       id;
    } exception_packet_t;

    typedef struct packed {
        word_t   rs1;
        offset_t offset;
        word_t   rs2;
        fn3_t    fn3;
        logic    load;
        logic    store;
        id_t     id;
    } ls_request_t;

endpackage
